/* mboxPkg.sv */
// Shared widths, diagnostic group codes and bus phase states for the memory-box control blocks.
package mboxPkg;

  // Physical page bits that pick a cache line.
  typedef logic [6:0] pageAdrT;

  // Word within a quadword.
  typedef logic [1:0] wordAdrT;

  // Bit i requests word i of the quadword.
  typedef logic [3:0] rqMaskT;

  typedef logic [2:0] diagSelT;
  typedef logic [6:0] diagWordT;

  // Held cache way match.
  typedef logic [1:0] camSelT;

  typedef enum logic {
    phaseA,
    phaseB
  } phaseT;

  // Clock cycles per memory bus phase.
  localparam int PhaseLen = 2;

  // Diagnostic readback groups.
  localparam diagSelT DiagWrEn     = 3'd0;
  localparam diagSelT DiagPulses   = 3'd1;
  localparam diagSelT DiagRequest  = 3'd2;
  localparam diagSelT DiagCoreRd   = 3'd3;
  localparam diagSelT DiagStart    = 3'd4;
  localparam diagSelT DiagCacheAdr = 3'd5;
  localparam diagSelT DiagStatus   = 3'd6;
  localparam diagSelT DiagSpare    = 3'd7;

endpackage

/* cacheAdrSelect.sv */
// Cache address select with the refill address hold and the write-ok check.
`timescale 1ns/1ps

module cacheAdrSelect (
  input  logic             clk,
  input  logic             arstN,
  input  mboxPkg::pageAdrT pageAdr,
  input  mboxPkg::wordAdrT pageWord,
  input  logic             refillHold,
  input  logic             refillAdrEn,
  input  mboxPkg::wordAdrT mbSel,
  input  logic             firstWdAdrSel,
  input  mboxPkg::camSelT  matchIn,
  output mboxPkg::pageAdrT cacheAdr,
  output mboxPkg::wordAdrT wordAdr,
  output mboxPkg::camSelT  camSel,
  output logic             writeOk
);
  import mboxPkg::*;

  pageAdrT pageHold;
  wordAdrT wordHold;
  camSelT  matchHold;

  // Page address freezes for the whole refill.
  always_ff @(posedge clk) begin
    if (!refillHold) begin
      pageHold <= pageAdr;
      wordHold <= pageWord;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      matchHold <= '0;
    end else if (!refillHold) begin
      matchHold <= matchIn;
    end
  end

  always_comb begin
    cacheAdr = refillAdrEn ? pageHold : pageAdr;
    // First word of a refill comes from the MB select.
    if (firstWdAdrSel) begin
      wordAdr = mbSel;
    end else if (refillAdrEn) begin
      wordAdr = wordHold;
    end else begin
      wordAdr = pageWord;
    end
  end

  assign camSel = matchHold;

  // A write may go ahead unless it lands on the line under refill.
  assign writeOk = !refillHold || (pageAdr != pageHold);

endmodule

/* cacheWritePulses.sv */
// Cache clear timing chain, registered cache write pulses and the write enable decode.
`timescale 1ns/1ps

module cacheWritePulses (
  input  logic            clk,
  input  logic            arstN,
  input  logic            clearWrT0,
  input  logic            ebox3CoreRd,
  input  logic            writeOk,
  input  logic            anyValHold,
  input  logic            oneWordRd,
  input  logic            wrFromMem,
  input  logic            ebxWrT4,
  input  logic            cacheWrIn,
  input  logic            eCacheWrCyc,
  input  logic            rdPause2nd,
  input  mboxPkg::camSelT camSel,
  input  mboxPkg::camSelT matchIn,
  output logic            clrT1,
  output logic            clrT2,
  output logic            clrT3,
  output logic            valWrPulse,
  output logic            wrWrPulse,
  output logic            adrWrPulse,
  output logic            dataWrPulse,
  output logic            selLru,
  output logic            dataClrDone,
  output mboxPkg::rqMaskT cshWrEn
);
  import mboxPkg::*;

  logic   clrNoVal;
  logic   holdMatch;
  logic   matchLoad;
  camSelT matchLatched;

  // Clear with no valid words held rewrites the whole entry.
  assign clrNoVal  = clrT1 && !anyValHold && !oneWordRd;
  assign matchLoad = holdMatch || (dataClrDone && eCacheWrCyc);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      clrT1       <= 1'b0;
      clrT2       <= 1'b0;
      clrT3       <= 1'b0;
      valWrPulse  <= 1'b0;
      wrWrPulse   <= 1'b0;
      adrWrPulse  <= 1'b0;
      dataWrPulse <= 1'b0;
      selLru      <= 1'b0;
    end else begin
      clrT1       <= (clearWrT0 && writeOk) || ebox3CoreRd;
      clrT2       <= clrT1;
      clrT3       <= clrT2;
      valWrPulse  <= wrFromMem || ebxWrT4 || clrNoVal;
      wrWrPulse   <= ebxWrT4 || clrNoVal;
      adrWrPulse  <= clrNoVal;
      dataWrPulse <= cacheWrIn;
      selLru      <= (clrT1 || clrT2) && !anyValHold;
    end
  end

  // Done flag lives from the end of the clear until the EBOX write or a new clear.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      dataClrDone  <= 1'b0;
      holdMatch    <= 1'b0;
      matchLatched <= '0;
    end else begin
      dataClrDone <= clrT3 || (dataClrDone && !ebxWrT4 && !clrT1);
      holdMatch   <= (clrT1 && eCacheWrCyc) || (holdMatch && !ebxWrT4);
      if (matchLoad) begin
        matchLatched <= eCacheWrCyc ? matchIn : camSel;
      end
    end
  end

  // One-hot way enable, off during the read pause and one-word reads.
  always_comb begin
    if (rdPause2nd || oneWordRd) begin
      cshWrEn = '0;
    end else begin
      cshWrEn = rqMaskT'(1) << matchLatched;
    end
  end

endmodule

/* memStartCtl.sv */
// Memory bus phase tracker and per-phase memory start control with last acknowledge detect.
`timescale 1ns/1ps

module memStartCtl #(
  parameter int phaseLen = mboxPkg::PhaseLen
) (
  input  logic clk,
  input  logic arstN,
  input  logic startReq,
  input  logic coreRdInProg,
  input  logic memAcknA,
  input  logic memAcknB,
  input  logic nxmAckn,
  input  logic rqLeftZero,
  output logic aChangeComing,
  output logic bChangeComing,
  output logic memStartA,
  output logic memStartB,
  output logic acknPulse,
  output logic lastAckn
);
  import mboxPkg::*;

  localparam int CntW = (phaseLen > 1) ? $clog2(phaseLen) : 1;
  localparam logic [CntW-1:0] LastCnt = CntW'(phaseLen - 1);

  phaseT           phase;
  logic [CntW-1:0] phaseCnt;
  logic            phaseEnd;
  logic            anyStrobe;
  logic            startPending;
  logic            reqLive;
  logic            takeA;
  logic            takeB;
  logic            lastAcknSeen;

  assign phaseEnd  = (phaseCnt == LastCnt);
  assign anyStrobe = aChangeComing || bChangeComing;

  // Reset parks in B so the first strobe after reset opens phase A.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phase         <= phaseB;
      phaseCnt      <= LastCnt;
      aChangeComing <= 1'b0;
      bChangeComing <= 1'b0;
    end else if (phaseEnd) begin
      phase         <= (phase == phaseA) ? phaseB : phaseA;
      phaseCnt      <= '0;
      aChangeComing <= (phase == phaseB);
      bChangeComing <= (phase == phaseA);
    end else begin
      phaseCnt      <= phaseCnt + 1'b1;
      aChangeComing <= 1'b0;
      bChangeComing <= 1'b0;
    end
  end

  assign acknPulse = (memStartA && aChangeComing && (memAcknA || nxmAckn)) ||
                     (memStartB && bChangeComing && (memAcknB || nxmAckn));
  assign lastAckn  = acknPulse && rqLeftZero;

  // One start at a time, and no new start while a core read drains.
  assign reqLive = (startReq || startPending) && !coreRdInProg && !memStartA && !memStartB;
  assign takeA   = reqLive && aChangeComing;
  assign takeB   = reqLive && bChangeComing;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      startPending <= 1'b0;
      lastAcknSeen <= 1'b0;
      memStartA    <= 1'b0;
      memStartB    <= 1'b0;
    end else begin
      startPending <= (startPending || startReq) && !takeA && !takeB;
      lastAcknSeen <= lastAckn || (lastAcknSeen && !anyStrobe);
      // Start drops on the strobe after the last acknowledge.
      memStartA    <= takeA || (memStartA && !(lastAcknSeen && anyStrobe));
      memStartB    <= takeB || (memStartB && !(lastAcknSeen && anyStrobe));
    end
  end

endmodule

/* coreReadSeq.sv */
// Memory request latch, core read word sequencing, data valid delay and request parity.
`timescale 1ns/1ps

module coreReadSeq (
  input  logic             clk,
  input  logic             arstN,
  input  logic             memStartA,
  input  logic             memStartB,
  input  logic             rqHold,
  input  mboxPkg::rqMaskT  rqIn,
  input  logic             rdRqIn,
  input  logic             wrRqIn,
  input  mboxPkg::wordAdrT sbusAdr,
  input  logic             adrPar,
  input  logic             forceBadPar,
  input  logic             acknPulse,
  input  logic             aChangeComing,
  input  logic             bChangeComing,
  input  logic             memDataValidA,
  input  logic             memDataValidB,
  output mboxPkg::rqMaskT  memRq,
  output logic             memRdRq,
  output logic             memWrRq,
  output logic             memAdrPar,
  output mboxPkg::wordAdrT coreAdr,
  output logic             coreDataValid,
  output logic             coreRdInProg,
  output logic             rqLeftZero
);
  import mboxPkg::*;

  rqMaskT  rqLeft;
  rqMaskT  dvLeft;
  wordAdrT rqAdr;
  logic    parHold;
  logic    badParHold;
  logic    memStart;
  logic    memStartQ;
  logic    startRd;
  logic    dvM2;
  logic    dvM1;
  logic    dvLast;

  // Retires the lowest outstanding word of a mask.
  function automatic rqMaskT dropLowest(input rqMaskT m);
    return m & (m - rqMaskT'(1));
  endfunction

  assign memStart = memStartA || memStartB;
  assign startRd  = memStart && !memStartQ && memRdRq;
  assign dvM2     = (memDataValidA && aChangeComing) || (memDataValidB && bChangeComing);

  // At most one word left means this acknowledge is the last.
  assign rqLeftZero = (dropLowest(rqLeft) == '0);
  assign dvLast     = (dropLowest(dvLeft) == '0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memRq      <= '0;
      memRdRq    <= 1'b0;
      memWrRq    <= 1'b0;
      rqAdr      <= '0;
      parHold    <= 1'b0;
      badParHold <= 1'b0;
    end else if (rqHold) begin
      memRq      <= rqIn;
      memRdRq    <= rdRqIn;
      memWrRq    <= wrRqIn;
      rqAdr      <= sbusAdr;
      parHold    <= adrPar;
      badParHold <= forceBadPar;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rqLeft <= '0;
    end else if (rqHold) begin
      rqLeft <= rqIn;
    end else if (acknPulse) begin
      rqLeft <= dropLowest(rqLeft);
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memStartQ     <= 1'b0;
      dvM1          <= 1'b0;
      coreDataValid <= 1'b0;
      coreRdInProg  <= 1'b0;
      coreAdr       <= '0;
      dvLeft        <= '0;
    end else begin
      memStartQ     <= memStart;
      dvM1          <= dvM2;
      coreDataValid <= dvM1;
      // Read words arrive in order from the start word.
      if (startRd) begin
        coreAdr      <= rqAdr;
        dvLeft       <= memRq;
        coreRdInProg <= 1'b1;
      end else if (coreDataValid) begin
        coreAdr <= coreAdr + 1'b1;
        dvLeft  <= dropLowest(dvLeft);
        if (dvLast) begin
          coreRdInProg <= 1'b0;
        end
      end
    end
  end

  // Odd parity over the request, flipped for the bad parity test.
  assign memAdrPar = ~(^{parHold, memRdRq, memWrRq, memRq, rqAdr}) ^ badParHold;

endmodule

/* diagReadMux.sv */
// Diagnostic readback select of one status group onto the readback word.
`timescale 1ns/1ps

module diagReadMux (
  input  logic              diagEn,
  input  mboxPkg::diagSelT  diagSel,
  input  mboxPkg::diagWordT statusG0,
  input  mboxPkg::diagWordT statusG1,
  input  mboxPkg::diagWordT statusG2,
  input  mboxPkg::diagWordT statusG3,
  input  mboxPkg::diagWordT statusG4,
  input  mboxPkg::diagWordT statusG5,
  input  mboxPkg::diagWordT statusG6,
  input  mboxPkg::diagWordT statusG7,
  output mboxPkg::diagWordT diagData
);
  import mboxPkg::*;

  always_comb begin
    diagData = '0;
    if (diagEn) begin
      case (diagSel)
        DiagWrEn:     diagData = statusG0;
        DiagPulses:   diagData = statusG1;
        DiagRequest:  diagData = statusG2;
        DiagCoreRd:   diagData = statusG3;
        DiagStart:    diagData = statusG4;
        DiagCacheAdr: diagData = statusG5;
        DiagStatus:   diagData = statusG6;
        DiagSpare:    diagData = statusG7;
        default:      diagData = '0;
      endcase
    end
  end

endmodule

/* mboxControl.sv */
// Memory-box control top level joining address select, write pulses, start, core read and diag.
`timescale 1ns/1ps

module mboxControl #(
  parameter int phaseLen = mboxPkg::PhaseLen
) (
  input  logic               clk,
  input  logic               arstN,
  input  mboxPkg::pageAdrT   pageAdr,
  input  mboxPkg::wordAdrT   pageWord,
  input  logic               refillHold,
  input  logic               refillAdrEn,
  input  mboxPkg::wordAdrT   mbSel,
  input  logic               firstWdAdrSel,
  input  mboxPkg::camSelT    matchIn,
  input  logic               clearWrT0,
  input  logic               ebox3CoreRd,
  input  logic               anyValHold,
  input  logic               oneWordRd,
  input  logic               wrFromMem,
  input  logic               ebxWrT4,
  input  logic               cacheWrIn,
  input  logic               eCacheWrCyc,
  input  logic               rdPause2nd,
  input  logic               startReq,
  input  logic               memAcknA,
  input  logic               memAcknB,
  input  logic               nxmAckn,
  input  logic               rqHold,
  input  mboxPkg::rqMaskT    rqIn,
  input  logic               rdRqIn,
  input  logic               wrRqIn,
  input  mboxPkg::wordAdrT   sbusAdr,
  input  logic               adrPar,
  input  logic               forceBadPar,
  input  logic               memDataValidA,
  input  logic               memDataValidB,
  input  logic               diagEn,
  input  mboxPkg::diagSelT   diagSel,
  output mboxPkg::pageAdrT   cacheAdr,
  output mboxPkg::wordAdrT   wordAdr,
  output mboxPkg::camSelT    camSel,
  output logic               writeOk,
  output logic               clrT1,
  output logic               clrT2,
  output logic               clrT3,
  output logic               valWrPulse,
  output logic               wrWrPulse,
  output logic               adrWrPulse,
  output logic               dataWrPulse,
  output logic               selLru,
  output logic               dataClrDone,
  output mboxPkg::rqMaskT    cshWrEn,
  output logic               aChangeComing,
  output logic               bChangeComing,
  output logic               memStartA,
  output logic               memStartB,
  output logic               acknPulse,
  output logic               lastAckn,
  output mboxPkg::rqMaskT    memRq,
  output logic               memRdRq,
  output logic               memWrRq,
  output logic               memAdrPar,
  output mboxPkg::wordAdrT   coreAdr,
  output logic               coreDataValid,
  output logic               coreRdInProg,
  output mboxPkg::diagWordT  diagData
);
  import mboxPkg::*;

  logic     rqLeftZero;
  diagWordT statusG0;
  diagWordT statusG1;
  diagWordT statusG2;
  diagWordT statusG3;
  diagWordT statusG4;
  diagWordT statusG5;
  diagWordT statusG6;

  cacheAdrSelect cacheAdrSelect0 (.*);

  cacheWritePulses cacheWritePulses0 (.*);

  memStartCtl #(
    .phaseLen(phaseLen)
  ) memStartCtl0 (.*);

  coreReadSeq coreReadSeq0 (.*);

  // Status groups, MSB first, zero filled above the listed fields.
  assign statusG0 = {1'b0, cshWrEn, camSel};
  assign statusG1 = {clrT1, clrT2, clrT3, valWrPulse, wrWrPulse, adrWrPulse, dataWrPulse};
  assign statusG2 = {1'b0, memRq, memRdRq, memWrRq};
  assign statusG3 = {3'b000, coreAdr, coreDataValid, coreRdInProg};
  assign statusG4 = {3'b000, memStartA, memStartB, aChangeComing, bChangeComing};
  assign statusG5 = cacheAdr;
  assign statusG6 = {5'b00000, writeOk, memAdrPar};

  // Group 7 is the spare group and reads as zero.
  diagReadMux diagReadMux0 (
    .statusG7('0),
    .*
  );

endmodule

/* tbMboxControl.sv */
// Testbench for the memory-box control top level; run it as the simulation top with sources.f.
`timescale 1ns/1ps

module tbMboxControl;
  import mboxPkg::*;

  localparam int HalfPeriod  = 2;
  localparam int NumReads    = 16;
  localparam int WatchCycles = 200 * NumReads + 1000;

  logic     clk = 1'b0;
  logic     arstN;
  pageAdrT  pageAdr;
  wordAdrT  pageWord;
  logic     refillHold;
  logic     refillAdrEn;
  wordAdrT  mbSel;
  logic     firstWdAdrSel;
  camSelT   matchIn;
  logic     clearWrT0;
  logic     ebox3CoreRd;
  logic     anyValHold;
  logic     oneWordRd;
  logic     wrFromMem;
  logic     ebxWrT4;
  logic     cacheWrIn;
  logic     eCacheWrCyc;
  logic     rdPause2nd;
  logic     startReq;
  logic     memAcknA = 1'b0;
  logic     memAcknB = 1'b0;
  logic     nxmAckn;
  logic     rqHold;
  rqMaskT   rqIn;
  logic     rdRqIn;
  logic     wrRqIn;
  wordAdrT  sbusAdr;
  logic     adrPar;
  logic     forceBadPar;
  logic     memDataValidA = 1'b0;
  logic     memDataValidB = 1'b0;
  logic     diagEn;
  diagSelT  diagSel;
  pageAdrT  cacheAdr;
  wordAdrT  wordAdr;
  camSelT   camSel;
  logic     writeOk;
  logic     clrT1;
  logic     clrT2;
  logic     clrT3;
  logic     valWrPulse;
  logic     wrWrPulse;
  logic     adrWrPulse;
  logic     dataWrPulse;
  logic     selLru;
  logic     dataClrDone;
  rqMaskT   cshWrEn;
  logic     aChangeComing;
  logic     bChangeComing;
  logic     memStartA;
  logic     memStartB;
  logic     acknPulse;
  logic     lastAckn;
  rqMaskT   memRq;
  logic     memRdRq;
  logic     memWrRq;
  logic     memAdrPar;
  wordAdrT  coreAdr;
  logic     coreDataValid;
  logic     coreRdInProg;
  diagWordT diagData;

  int       errCount   = 0;
  int       checkCount = 0;
  pageAdrT  heldPage   = '0;
  wordAdrT  heldWord   = '0;
  camSelT   heldMatch  = '0;
  wordAdrT  curStart   = '0;
  wordAdrT  lastEndAdr = '0;
  rqMaskT   lastMask   = '0;
  camSelT   lastMatch  = '0;
  logic     lastParExp = 1'b0;

  // Memory model state.
  logic       modelBusy   = 1'b0;
  logic       modelOnB    = 1'b0;
  logic       modelStartQ = 1'b0;
  logic       dvOwed      = 1'b0;
  logic       dvNow;
  int         wordsToAck  = 0;
  int         ackWait     = 0;
  int         wordsOpen   = 0;
  logic [1:0] dvHist      = 2'b00;

  // Monitor state.
  logic startAQ   = 1'b0;
  logic startBQ   = 1'b0;
  logic aStrobeQ  = 1'b0;
  logic bStrobeQ  = 1'b0;
  logic rdInProgQ = 1'b0;
  logic aSeen     = 1'b0;
  int   sinceA    = 0;
  int   dvCount   = 0;

  mboxControl #(
    .phaseLen(PhaseLen)
  ) dut0 (.*);

  always #HalfPeriod clk = ~clk;

  function automatic int onesIn(input logic [8:0] bits);
    int n;
    int i;
    n = 0;
    for (i = 0; i < 9; i++) begin
      n += bits[i];
    end
    return n;
  endfunction

  function automatic pageAdrT expCacheAdr(input logic adrEn, input pageAdrT live,
                                          input pageAdrT held);
    return adrEn ? held : live;
  endfunction

  function automatic wordAdrT expWordAdr(input logic firstSel, input logic adrEn,
                                         input wordAdrT mb, input wordAdrT live,
                                         input wordAdrT held);
    if (firstSel) begin
      return mb;
    end
    return adrEn ? held : live;
  endfunction

  function automatic logic expWriteOk(input logic hold, input pageAdrT live, input pageAdrT held);
    return !hold || (live != held);
  endfunction

  function automatic rqMaskT expWrEn(input camSelT match, input logic pause);
    return pause ? 4'b0000 : (4'b0001 << match);
  endfunction

  // Odd parity, so the parity bit is set when the covered bits hold an even count of ones.
  function automatic logic expParity(input logic par, input logic rd, input logic wr,
                                     input rqMaskT mask, input wordAdrT adr, input logic bad);
    return ((onesIn({par, rd, wr, mask, adr}) % 2) == 0) ^ bad;
  endfunction

  function automatic wordAdrT expCoreAdr(input wordAdrT start, input int k);
    return wordAdrT'(start + k);
  endfunction

  task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic initInputs();
    pageAdr       = '0;
    pageWord      = '0;
    refillHold    = 1'b0;
    refillAdrEn   = 1'b0;
    mbSel         = '0;
    firstWdAdrSel = 1'b0;
    matchIn       = '0;
    clearWrT0     = 1'b0;
    ebox3CoreRd   = 1'b0;
    anyValHold    = 1'b0;
    oneWordRd     = 1'b0;
    wrFromMem     = 1'b0;
    ebxWrT4       = 1'b0;
    cacheWrIn     = 1'b0;
    eCacheWrCyc   = 1'b0;
    rdPause2nd    = 1'b0;
    startReq      = 1'b0;
    nxmAckn       = 1'b0;
    rqHold        = 1'b0;
    rqIn          = '0;
    rdRqIn        = 1'b0;
    wrRqIn        = 1'b0;
    sbusAdr       = '0;
    adrPar        = 1'b0;
    forceBadPar   = 1'b0;
    diagEn        = 1'b0;
    diagSel       = '0;
  endtask

  task automatic testAddressSelect();
    int i;
    for (i = 0; i < 32; i++) begin
      @(negedge clk);
      // Reuse the held page now and then so the write conflict shows up.
      pageAdr       = ($urandom % 3 == 0) ? heldPage : pageAdrT'($urandom);
      pageWord      = wordAdrT'($urandom);
      mbSel         = wordAdrT'($urandom);
      refillHold    = (i == 0) ? 1'b0 : 1'($urandom);
      refillAdrEn   = (i == 0) ? 1'b0 : 1'($urandom);
      firstWdAdrSel = ($urandom % 4 == 0);
      matchIn       = camSelT'($urandom);
      #1;
      checkEq(cacheAdr, expCacheAdr(refillAdrEn, pageAdr, heldPage), "cacheAdr");
      checkEq(wordAdr, expWordAdr(firstWdAdrSel, refillAdrEn, mbSel, pageWord, heldWord),
              "wordAdr");
      checkEq(writeOk, expWriteOk(refillHold, pageAdr, heldPage), "writeOk");
      checkEq(camSel, heldMatch, "camSel");
      @(posedge clk);
      if (!refillHold) begin
        heldPage  = pageAdr;
        heldWord  = pageWord;
        heldMatch = matchIn;
      end
    end
    @(negedge clk);
    refillHold    = 1'b0;
    refillAdrEn   = 1'b0;
    firstWdAdrSel = 1'b0;
  endtask

  task automatic testWritePulses();
    int     i;
    camSelT m;
    for (i = 0; i < 6; i++) begin
      m = camSelT'($urandom);
      @(negedge clk);
      matchIn     = m;
      eCacheWrCyc = 1'b1;
      clearWrT0   = 1'b1;
      @(negedge clk);
      clearWrT0 = 1'b0;
      checkEq({clrT1, clrT2, clrT3}, 3'b100, "clear chain at T1");
      checkEq({valWrPulse, wrWrPulse, adrWrPulse, selLru}, 4'b0000, "entry write at T1");
      @(negedge clk);
      checkEq({clrT1, clrT2, clrT3}, 3'b010, "clear chain at T2");
      // No valid words held, so the whole entry is rewritten into the LRU way.
      checkEq({valWrPulse, wrWrPulse, adrWrPulse, selLru}, 4'b1111, "entry write at T2");
      @(negedge clk);
      checkEq({clrT1, clrT2, clrT3}, 3'b001, "clear chain at T3");
      checkEq({valWrPulse, wrWrPulse, adrWrPulse, selLru, dataClrDone}, 5'b00010,
              "entry write at T3");
      @(negedge clk);
      checkEq({selLru, dataClrDone}, 2'b01, "clear done after T3");
      checkEq(cshWrEn, expWrEn(m, 1'b0), "cshWrEn decode");
      rdPause2nd = !i[0];
      oneWordRd  = i[0];
      #1;
      checkEq(cshWrEn, expWrEn(m, 1'b1), "cshWrEn during read pause or one-word read");
      @(negedge clk);
      rdPause2nd = 1'b0;
      oneWordRd  = 1'b0;
      lastMatch  = m;
    end
    @(negedge clk);
    cacheWrIn = 1'b1;
    wrFromMem = 1'b1;
    @(negedge clk);
    cacheWrIn = 1'b0;
    wrFromMem = 1'b0;
    checkEq({dataWrPulse, valWrPulse}, 2'b11, "write pulses one clock after cause");
    @(negedge clk);
    checkEq({dataWrPulse, valWrPulse}, 2'b00, "write pulses one clock wide");
  endtask

  task automatic latchRequest(input rqMaskT mask, input logic rd, input logic wr,
                              input wordAdrT adr, input logic par, input logic bad);
    @(negedge clk);
    rqHold      = 1'b1;
    rqIn        = mask;
    rdRqIn      = rd;
    wrRqIn      = wr;
    sbusAdr     = adr;
    adrPar      = par;
    forceBadPar = bad;
    @(negedge clk);
    rqHold     = 1'b0;
    lastMask   = mask;
    lastParExp = expParity(par, rd, wr, mask, adr, bad);
    checkEq({memRq, memRdRq, memWrRq}, {mask, rd, wr}, "latched request");
    checkEq(memAdrPar, lastParExp, "memAdrPar");
  endtask

  task automatic runRead();
    rqMaskT  mask;
    wordAdrT start;
    mask     = rqMaskT'(1 + $urandom % 15);
    start    = wordAdrT'($urandom);
    curStart = start;
    latchRequest(mask, 1'b1, 1'b0, start, 1'($urandom), 1'($urandom));
    startReq = 1'b1;
    @(negedge clk);
    startReq = 1'b0;
    do begin
      @(negedge clk);
    end while (!memStartA && !memStartB);
    do begin
      @(negedge clk);
    end while (memStartA || memStartB || coreRdInProg);
    checkEq(dvCount, onesIn({5'b0, mask}), "coreDataValid pulses for the read");
    lastEndAdr = expCoreAdr(start, onesIn({5'b0, mask}));
  endtask

  task automatic testDiag();
    diagWordT expGroup [8];
    int       sel;
    @(negedge clk);
    pageAdr     = 7'h5a;
    expGroup[0] = {1'b0, expWrEn(lastMatch, 1'b0), lastMatch};
    expGroup[1] = '0;
    expGroup[2] = {1'b0, lastMask, 1'b1, 1'b0};
    expGroup[3] = {3'b000, lastEndAdr, 2'b00};
    expGroup[4] = 7'b0000010;
    expGroup[5] = 7'h5a;
    expGroup[6] = {5'b00000, 1'b1, lastParExp};
    expGroup[7] = '0;
    for (sel = 0; sel < 8; sel++) begin
      // Line up with an A strobe so the phase bits of group 4 are known.
      do begin
        @(negedge clk);
      end while (!aChangeComing);
      diagEn  = 1'b1;
      diagSel = diagSelT'(sel);
      #1;
      checkEq(diagData, expGroup[sel], $sformatf("diagData for group %0d", sel));
      @(negedge clk);
      diagEn = 1'b0;
      #1;
      checkEq(diagData, 7'b0, "diagData with diagEn low");
    end
  endtask

  // Memory answers one word per own-phase strobe after a random wait, data valid one strobe later.
  always @(negedge clk) begin
    dvNow         = 1'b0;
    memAcknA      = 1'b0;
    memAcknB      = 1'b0;
    memDataValidA = 1'b0;
    memDataValidB = 1'b0;
    if ((memStartA || memStartB) && !modelStartQ) begin
      modelBusy  = 1'b1;
      modelOnB   = memStartB;
      wordsToAck = onesIn({5'b0, memRq});
      ackWait    = $urandom % 4;
      dvOwed     = 1'b0;
      wordsOpen <= wordsToAck;
    end
    modelStartQ = memStartA || memStartB;
    if (modelBusy && (modelOnB ? bChangeComing : aChangeComing)) begin
      if (dvOwed) begin
        memDataValidA = !modelOnB;
        memDataValidB = modelOnB;
        dvNow         = 1'b1;
        dvOwed        = 1'b0;
      end
      if (wordsToAck > 0) begin
        if (ackWait == 0) begin
          memAcknA   = !modelOnB;
          memAcknB   = modelOnB;
          wordsToAck = wordsToAck - 1;
          wordsOpen <= wordsToAck;
          dvOwed     = 1'b1;
          ackWait    = $urandom % 4;
        end else begin
          ackWait = ackWait - 1;
        end
      end else if (!dvOwed) begin
        modelBusy = 1'b0;
      end
    end
    dvHist <= {dvHist[0], dvNow};
  end

  // Bus and core read rules checked every cycle.
  always @(negedge clk) begin
    sinceA = sinceA + 1;
    checkEq(memStartA && memStartB, 1'b0, "memStartA and memStartB overlap");
    if (memStartA && !startAQ) begin
      checkEq(aStrobeQ, 1'b1, "memStartA set away from an A strobe");
    end
    if (memStartB && !startBQ) begin
      checkEq(bStrobeQ, 1'b1, "memStartB set away from a B strobe");
    end
    if ((startAQ || startBQ) && !memStartA && !memStartB) begin
      checkEq(wordsOpen, 0, "memory start cleared with acknowledges open");
    end
    checkEq(coreDataValid, dvHist[1], "coreDataValid two clocks after data valid");
    if (coreRdInProg && !rdInProgQ) begin
      dvCount = 0;
    end
    if (coreDataValid) begin
      checkEq(coreAdr, expCoreAdr(curStart, dvCount), "coreAdr at coreDataValid");
      dvCount = dvCount + 1;
    end
    if (aChangeComing) begin
      if (aSeen) begin
        checkEq(sinceA, 2 * PhaseLen, "A strobe spacing");
      end
      aSeen  = 1'b1;
      sinceA = 0;
    end
    if (bChangeComing) begin
      checkEq(sinceA, PhaseLen, "B strobe offset");
    end
    startAQ   = memStartA;
    startBQ   = memStartB;
    aStrobeQ  = aChangeComing;
    bStrobeQ  = bChangeComing;
    rdInProgQ = coreRdInProg;
  end

  // Acknowledge decode, looked at once the memory model has driven the bus.
  always @(negedge clk) begin
    #1;
    checkEq(acknPulse, memAcknA || memAcknB, "acknPulse");
    checkEq(lastAckn, (memAcknA || memAcknB) && (wordsOpen == 0), "lastAckn");
  end

  initial begin
    #(WatchCycles * 2 * HalfPeriod);
    $display("Timeout: the run did not finish within %0d cycles", WatchCycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int i;
    void'($urandom(32'h2293_30e8));
    initInputs();
    arstN = 1'b0;
    repeat (5) @(negedge clk);
    checkEq({memStartA, memStartB, clrT1, clrT2, clrT3, valWrPulse, wrWrPulse, adrWrPulse,
             dataWrPulse, coreDataValid, coreRdInProg}, '0, "control outputs in reset");
    arstN = 1'b1;
    @(negedge clk);
    checkEq(aChangeComing, 1'b1, "first A strobe after reset");
    testAddressSelect();
    testWritePulses();
    for (i = 0; i < 8; i++) begin
      latchRequest(rqMaskT'($urandom), 1'($urandom), 1'($urandom), wordAdrT'($urandom),
                   1'($urandom), 1'($urandom));
    end
    for (i = 0; i < NumReads; i++) begin
      runRead();
    end
    testDiag();
    repeat (4) @(negedge clk);
    $display("Checks run: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sources.f */
mboxPkg.sv
cacheAdrSelect.sv
cacheWritePulses.sv
memStartCtl.sv
coreReadSeq.sv
diagReadMux.sv
mboxControl.sv
tbMboxControl.sv

/* Bender.yml */
package:
  name: mbox_control

sources:
  - mboxPkg.sv
  - cacheAdrSelect.sv
  - cacheWritePulses.sv
  - memStartCtl.sv
  - coreReadSeq.sv
  - diagReadMux.sv
  - mboxControl.sv
  - target: test
    files:
      - tbMboxControl.sv
